// ==== src.f ====
rtl/ps2_pkg.sv
rtl/ps2_frame_shifter.sv
rtl/ps2_line_timer.sv
rtl/ps2_host_fsm.sv
rtl/ps2_report_accum.sv
rtl/ps2_apb_regs.sv
rtl/ps2_mouse_top.sv
verif/ps2_mouse_model.sv
verif/tb_ps2_mouse.sv

// ==== Makefile ====
# verilator flow for the ps/2 mouse host controller
SIM        := verilator
TOP        := tb_ps2_mouse
FILELIST   := src.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := all tests passed
COMMON     := --timing --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS := --lint-only
SIM_FLAGS  := --binary -j 0 -Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) $(COMMON)

sim:
	$(SIM) $(SIM_FLAGS) $(COMMON)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed, see $(LOG)"; \
	else \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/tb_ps2_mouse.sv ====
`timescale 1ns/10ps
module tb_ps2_mouse;
  import ps2_pkg::*;

  localparam logic [31:0] SEED = 32'h52bb;
  localparam int NPKT     = 200;
  localparam int NERR     = 5;
  localparam int NEXTRA   = 2;                          // recovery and post-restart packets
  localparam int BIT_CYC  = 40;                         // one ps/2 bit in system cycles
  localparam int INIT_CYC = 2 * 7 * 2 * 11 * BIT_CYC * 2;  // two init runs, command and reply
  localparam int LIMIT    = 3 * (NPKT + NERR + NEXTRA) * 4 * 11 * BIT_CYC / 2 + INIT_CYC;
  localparam logic [7:0] INIT_REF [7] = '{8'hF3, 8'hC8, 8'hF3, 8'h64, 8'hF3, 8'h50, 8'hF4};

  logic       clk, arst_n;
  apb_req_t   apb_req;
  apb_rsp_t   apb_rsp;
  ps2_drive_t drive;
  logic       ps2_clk, ps2_dat, dev_clk, dev_dat;
  logic       tx_req, tx_bad, mdl_busy, cmd_valid, cmd_ok;
  logic [7:0] tx_data, cmd_byte;
  logic [8:0] cmd_q[$];                 // {parity ok, byte} seen by the mouse
  pos_t       x_ref, y_ref, z_ref;      // reference accumulator
  logic [2:0] btn_ref;
  int         err_ref;
  int         n_checks, n_err, n_tests, n_bad;
  int         cyc = 0;

  assign ps2_clk = dev_clk & ~drive.clk_oe;  // open-drain bus
  assign ps2_dat = dev_dat & ~drive.dat_oe;

  ps2_mouse_top #(
    .wheel_ena(1'b1), .hold_cycles(60), .watchdog_cycles(400), .filter_len(4)
  ) UUT (
    .clk, .arst_n, .apb_req, .apb_rsp, .ps2_clk, .ps2_dat, .drive
  );

  ps2_mouse_model #(.half_cycles(BIT_CYC / 2), .gap_cycles(20)) u_mouse (
    .clk, .line_clk(ps2_clk), .line_dat(ps2_dat), .dev_clk, .dev_dat, .tx_req, .tx_data,
    .tx_bad, .busy(mdl_busy), .cmd_valid, .cmd_byte, .cmd_ok
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(negedge clk) begin
    if (cmd_valid) cmd_q.push_back({cmd_ok, cmd_byte});
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= LIMIT) begin
      $display("timeout: run still going after %0d cycles", LIMIT);
      $display("tests failed");
      $finish;
    end
  end

  function automatic apb_rsp_t expect_rsp(input logic [31:0] data, input logic slverr);
    apb_rsp_t r;
    r.prdata  = data;
    r.pready  = 1'b1;  // no wait states
    r.pslverr = slverr;
    return r;
  endfunction

  task automatic compare_pos(input pos_t got, input pos_t exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_err++;
      $display("FAILED %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic compare_btn(input logic [2:0] got, input logic [2:0] exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_err++;
      $display("FAILED %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic compare_cmd(input logic [8:0] got, input logic [8:0] exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_err++;
      $display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_rsp(input apb_rsp_t got, input apb_rsp_t exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_err++;
      $display("FAILED %0t: %s got %h/%b/%b expected %h/%b/%b", $time, what,
               got.prdata, got.pready, got.pslverr, exp.prdata, exp.pready, exp.pslverr);
    end
  endtask

  // setup then access phase, response taken mid access cycle
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output apb_rsp_t rsp);
    @(posedge clk);
    #1;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    @(negedge clk);
    rsp = apb_rsp;
    @(posedge clk);
    #1;
    apb_req = '0;
  endtask

  task automatic wait_status_bit(input int b);
    apb_rsp_t rsp;
    rsp = '0;
    while (!rsp.prdata[b]) apb_access(1'b0, REG_STATUS, '0, rsp);
  endtask

  task automatic clear_report();
    apb_rsp_t rsp;
    apb_access(1'b1, REG_STATUS, 32'h2, rsp);
  endtask

  task automatic send_byte(input logic [7:0] b, input logic bad);
    @(negedge clk);
    while (mdl_busy) @(negedge clk);
    @(posedge clk);
    #1;
    tx_data = b;
    tx_bad  = bad;
    tx_req  = 1'b1;
    @(negedge clk);
    while (!mdl_busy) @(negedge clk);  // mouse has taken it
    @(posedge clk);
    #1;
    tx_req = 1'b0;
  endtask

  task automatic send_packet(input logic [3:0][7:0] pkt, input int bad_idx);
    for (int i = 0; i < 4; i++) send_byte(pkt[i], i == bad_idx);
  endtask

  task automatic wait_mouse_idle();
    @(negedge clk);
    while (mdl_busy) @(negedge clk);
    repeat (4) @(negedge clk);
  endtask

  task automatic random_packet(output logic [3:0][7:0] pkt);
    logic [8:0] dx, dy;
    logic [3:0] dz;
    logic [1:0] ovf;
    dx  = 9'($urandom);
    dy  = 9'($urandom);
    dz  = 4'($urandom);
    ovf = ($urandom % 10 == 0) ? 2'($urandom_range(3, 1)) : 2'b00;  // {y, x} overflow
    pkt[0] = {ovf, dy[8], dx[8], 1'b1, 3'($urandom)};
    pkt[1] = dx[7:0];
    pkt[2] = dy[7:0];
    pkt[3] = {{4{dz[3]}}, dz};
  endtask

  // 9-bit two's complement deltas, z from the low nibble, screen y runs down
  task automatic apply_report(input logic [7:0] b0, b1, b2, b3);
    int dx, dy, dz;
    dx = b0[6] ? 0 : int'(b1) - (b0[4] ? 256 : 0);
    dy = b0[7] ? 0 : int'(b2) - (b0[5] ? 256 : 0);
    dz = int'(b3[3:0]) - (b3[3] ? 16 : 0);
    x_ref   = pos_t'(int'(x_ref) + dx);
    y_ref   = pos_t'(int'(y_ref) - dy);
    z_ref   = pos_t'(int'(z_ref) + dz);
    btn_ref = b0[2:0];
  endtask

  task automatic check_pos_all(input string tag);
    apb_rsp_t rsp;
    apb_access(1'b0, REG_X, '0, rsp);
    compare_pos(pos_t'(rsp.prdata[15:0]), x_ref, {tag, " x"});
    apb_access(1'b0, REG_Y, '0, rsp);
    compare_pos(pos_t'(rsp.prdata[15:0]), y_ref, {tag, " y"});
    apb_access(1'b0, REG_Z, '0, rsp);
    compare_pos(pos_t'(rsp.prdata[15:0]), z_ref, {tag, " z"});
  endtask

  task automatic check_state(input string tag);
    apb_rsp_t rsp;
    check_pos_all(tag);
    apb_access(1'b0, REG_BTN, '0, rsp);
    compare_btn(rsp.prdata[2:0], btn_ref, {tag, " btn"});
  endtask

  task automatic good_packet(input string tag);
    logic [3:0][7:0] pkt;
    random_packet(pkt);
    send_packet(pkt, -1);
    wait_status_bit(1);  // new report
    apply_report(pkt[0], pkt[1], pkt[2], pkt[3]);
    check_state(tag);
    clear_report();
  endtask

  task automatic check_init(input string tag);
    apb_rsp_t rsp;
    while (cmd_q.size() < 7) @(negedge clk);
    for (int i = 0; i < 7; i++) begin
      compare_cmd(cmd_q[i], {1'b1, INIT_REF[i]}, {tag, " command"});
    end
    cmd_q.delete();
    wait_status_bit(0);  // run
    apb_access(1'b0, REG_STATUS, '0, rsp);
    compare_rsp(rsp, expect_rsp(32'h1, 1'b0), {tag, " status"});
  endtask

  task automatic end_test(input string name, input int err_before);
    n_tests++;
    if (n_err == err_before) begin
      $display("test %s: ok", name);
    end else begin
      n_bad++;
      $display("test %s: %0d mismatches", name, n_err - err_before);
    end
  endtask

  initial begin
    apb_rsp_t        rsp;
    logic [3:0][7:0] pkt;
    int              e0;
    int              bad;
    void'($urandom(SEED));
    arst_n  = 1'b0;
    apb_req = '0;
    tx_req  = 1'b0;
    tx_bad  = 1'b0;
    tx_data = '0;
    x_ref   = '0;
    y_ref   = '0;
    z_ref   = '0;
    btn_ref = '0;
    err_ref = 0;
    repeat (16) @(posedge clk);
    #1;
    arst_n = 1'b1;

    e0 = n_err;
    check_init("init");
    end_test("init", e0);

    e0 = n_err;
    for (int n = 0; n < NPKT; n++) good_packet("packet");
    end_test("random packets", e0);

    e0 = n_err;
    for (int n = 0; n < NERR; n++) begin
      random_packet(pkt);
      pkt[1][3] = 1'b0;  // trailing bytes never look like a packet start
      pkt[2][3] = 1'b0;
      pkt[3]    = 8'h00;
      bad = int'($urandom_range(3));
      send_packet(pkt, bad);
      wait_mouse_idle();
      err_ref++;
      apb_access(1'b0, REG_ERR, '0, rsp);
      compare_rsp(rsp, expect_rsp(32'(err_ref), 1'b0), "error count");
      apb_access(1'b0, REG_STATUS, '0, rsp);
      compare_rsp(rsp, expect_rsp(32'h1, 1'b0), "status after drop");
      check_state("dropped");
    end
    good_packet("recovery");
    end_test("parity errors", e0);

    e0 = n_err;
    apb_access(1'b1, REG_CTRL, 32'h2, rsp);
    x_ref = '0;
    y_ref = '0;
    z_ref = '0;
    check_pos_all("clear");
    apb_access(1'b1, REG_CTRL, 32'h1, rsp);
    check_init("restart");
    good_packet("after restart");
    end_test("control", e0);

    e0 = n_err;
    apb_access(1'b0, 8'h1C, '0, rsp);
    compare_rsp(rsp, expect_rsp('0, 1'b1), "unmapped read");
    apb_access(1'b1, 8'h40, 32'hffff_ffff, rsp);
    compare_rsp(rsp, expect_rsp('0, 1'b1), "unmapped write");
    apb_access(1'b0, REG_ERR, '0, rsp);
    compare_rsp(rsp, expect_rsp(32'(err_ref), 1'b0), "final error count");
    end_test("unmapped", e0);

    $display("tests %0d, failing %0d, checks %0d, mismatches %0d",
             n_tests, n_bad, n_checks, n_err);
    if (n_err == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== verif/ps2_mouse_model.sv ====
`timescale 1ns/10ps
module ps2_mouse_model #(
  parameter int half_cycles = 20,  // system cycles per ps/2 clock half period
  parameter int gap_cycles  = 20   // idle time after each sent byte
) (
  input  logic       clk,
  input  logic       line_clk,   // bus level after the wired-and
  input  logic       line_dat,
  output logic       dev_clk,    // 0 pulls the line low
  output logic       dev_dat,
  input  logic       tx_req,     // send tx_data to the host
  input  logic [7:0] tx_data,
  input  logic       tx_bad,     // flip the parity bit
  output logic       busy,
  output logic       cmd_valid,  // one cycle per host command
  output logic [7:0] cmd_byte,
  output logic       cmd_ok      // start, odd parity and stop all good
);

  localparam logic [7:0] ACK = 8'hFA;

  // line changes land just after the rising edge
  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // device to host, data valid while the clock is high
  task automatic send_frame(input logic [7:0] b, input logic bad);
    logic [10:0] bits;
    bits = {1'b1, (~^b) ^ bad, b, 1'b0};
    for (int i = 0; i < 11; i++) begin
      dev_dat = bits[i];
      step(half_cycles);
      dev_clk = 1'b0;  // host samples on this fall
      step(half_cycles);
      dev_clk = 1'b1;
    end
    dev_dat = 1'b1;
    step(half_cycles);
  endtask

  // host to device after a request-to-send
  task automatic recv_frame();
    logic [9:0] bits;
    logic       start;
    while (!line_clk) step(1);  // host still holds the clock
    step(half_cycles);
    start = line_dat;           // host pulled data low with the release
    for (int i = 0; i < 10; i++) begin
      dev_clk = 1'b0;
      step(half_cycles);
      dev_clk = 1'b1;
      step(half_cycles / 2);
      bits[i] = line_dat;       // settled well after the fall
      step(half_cycles - half_cycles / 2);
    end
    dev_dat = 1'b0;             // ack bit
    step(half_cycles / 2);
    dev_clk = 1'b0;
    step(half_cycles);
    dev_clk = 1'b1;
    step(half_cycles);
    dev_dat = 1'b1;
    cmd_byte  = bits[7:0];
    cmd_ok    = ~start & (^bits[8:0]) & bits[9];
    cmd_valid = 1'b1;
    step(1);
    cmd_valid = 1'b0;
  endtask

  initial begin
    logic [7:0] b;
    logic       bad;
    dev_clk   = 1'b1;
    dev_dat   = 1'b1;
    busy      = 1'b0;
    cmd_valid = 1'b0;
    cmd_byte  = '0;
    cmd_ok    = 1'b0;
    forever begin
      @(negedge clk);  // requests are looked at mid cycle
      if (tx_req) begin
        b   = tx_data;
        bad = tx_bad;
        step(1);
        busy = 1'b1;
        send_frame(b, bad);
        step(gap_cycles);
        busy = 1'b0;
      end else if (!line_clk && dev_clk) begin
        recv_frame();            // host is requesting to send
        step(2 * half_cycles);
        send_frame(ACK, 1'b0);   // every command gets FA back
      end
    end
  end

endmodule

// ==== rtl/ps2_mouse_top.sv ====
`timescale 1ns/10ps
module ps2_mouse_top #(
  parameter bit wheel_ena       = 1'b1,
  parameter int hold_cycles     = 5000,   // ~100 us at 50 MHz
  parameter int watchdog_cycles = 20000,
  parameter int filter_len      = 4
) (
  input  logic                clk,
  input  logic                arst_n,
  input  ps2_pkg::apb_req_t   apb_req,
  output ps2_pkg::apb_rsp_t   apb_rsp,
  input  logic                ps2_clk,
  input  logic                ps2_dat,
  output ps2_pkg::ps2_drive_t drive
);
  import ps2_pkg::*;

  logic         tx_start, tx_done, ack_ok, hold_start, hold_done;
  logic [7:0]   tx_byte;
  logic         clk_edge, in_frame, wd_expired;
  logic         rx_valid;
  ps2_frame_t   rx_frame;
  logic         run, init_fail, restart, clear;
  logic         new_report, err_inc;
  mouse_state_t state;

  ps2_frame_shifter #(.filter_len(filter_len)) u_shifter (
    .clk, .arst_n, .ps2_clk, .ps2_dat, .tx_start, .tx_byte, .hold_done, .wd_expired,
    .drive, .clk_edge, .in_frame, .rx_valid, .rx_frame, .tx_done, .ack_ok
  );

  ps2_line_timer #(.hold_cycles(hold_cycles), .watchdog_cycles(watchdog_cycles)) u_timer (
    .clk, .arst_n, .hold_start, .clk_edge, .in_frame, .hold_done, .wd_expired
  );

  ps2_host_fsm u_fsm (
    .clk, .arst_n, .restart, .rx_valid, .rx_frame, .tx_done, .ack_ok, .wd_expired,
    .hold_start, .tx_start, .tx_byte, .run, .init_fail
  );

  ps2_report_accum #(.wheel_ena(wheel_ena)) u_accum (
    .clk, .arst_n, .run, .clear, .rx_valid, .rx_frame, .state, .new_report, .err_inc
  );

  ps2_apb_regs u_regs (
    .clk, .arst_n, .apb_req, .apb_rsp, .state, .new_report, .run, .err_inc, .init_fail,
    .clear, .restart
  );

endmodule

// ==== rtl/ps2_apb_regs.sv ====
`timescale 1ns/10ps
module ps2_apb_regs (
  input  logic                  clk,
  input  logic                  arst_n,
  input  ps2_pkg::apb_req_t     apb_req,
  output ps2_pkg::apb_rsp_t     apb_rsp,
  input  ps2_pkg::mouse_state_t state,
  input  logic                  new_report,
  input  logic                  run,
  input  logic                  err_inc,
  input  logic                  init_fail,
  output logic                  clear,
  output logic                  restart
);
  import ps2_pkg::*;

  logic        access;    // apb access phase
  logic        wr;
  logic        mapped;
  logic [31:0] rd_data;
  logic        new_flag;  // sticky report flag
  logic [15:0] err_cnt;

  assign access = apb_req.psel & apb_req.penable;
  assign wr     = access & apb_req.pwrite;

  always_comb begin
    rd_data = '0;
    mapped  = 1'b1;
    case (apb_req.paddr)
      REG_STATUS: rd_data = {30'b0, new_flag, run};
      REG_CTRL:   rd_data = '0;  // pulses only, reads back 0
      REG_X:      rd_data = {{16{state.x[15]}}, state.x};
      REG_Y:      rd_data = {{16{state.y[15]}}, state.y};
      REG_Z:      rd_data = {{16{state.z[15]}}, state.z};
      REG_BTN:    rd_data = {29'b0, state.btn};
      REG_ERR:    rd_data = {16'b0, err_cnt};
      default:    mapped  = 1'b0;
    endcase
  end

  assign apb_rsp.prdata  = (apb_req.psel && !apb_req.pwrite) ? rd_data : '0;
  assign apb_rsp.pready  = 1'b1;  // zero wait states
  assign apb_rsp.pslverr = (access && !mapped) ? RESP_SLVERR : RESP_OKAY;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      new_flag <= 1'b0;
      err_cnt  <= '0;
      clear    <= 1'b0;
      restart  <= 1'b0;
    end else begin
      clear   <= wr & (apb_req.paddr == REG_CTRL) & apb_req.pwdata[1];
      restart <= wr & (apb_req.paddr == REG_CTRL) & apb_req.pwdata[0];
      // a fresh report wins over a clear in the same cycle
      if (new_report) new_flag <= 1'b1;
      else if (wr && apb_req.paddr == REG_STATUS && apb_req.pwdata[1]) new_flag <= 1'b0;
      err_cnt <= err_cnt + {15'b0, err_inc} + {15'b0, init_fail};
    end
  end

endmodule

// ==== rtl/ps2_report_accum.sv ====
`timescale 1ns/10ps
module ps2_report_accum #(
  parameter bit wheel_ena = 1'b1
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  run,
  input  logic                  clear,
  input  logic                  rx_valid,
  input  ps2_pkg::ps2_frame_t   rx_frame,
  output ps2_pkg::mouse_state_t state,
  output logic                  new_report,
  output logic                  err_inc
);
  import ps2_pkg::*;

  localparam logic [1:0] LAST = wheel_ena ? 2'd3 : 2'd2;  // index of final byte

  logic [1:0] cnt;         // bytes collected so far
  logic [7:0] b0, b1, b2;  // earlier packet bytes
  logic [7:0] pb2, pb3;    // bytes 2 and 3 as seen when packet completes
  logic       take;        // clean byte in run mode
  pos_t       dx, dy, dz;
  pos_t       x, y, z;
  logic [2:0] btn;

  assign take = rx_valid & run & ~rx_frame.err;
  assign pb2  = wheel_ena ? b2 : rx_frame.data;
  assign pb3  = wheel_ena ? rx_frame.data : 8'h00;

  // byte 0: {y ovf, x ovf, y sign, x sign, 1, m, r, l}
  assign dx = b0[6] ? '0 : {{8{b0[4]}}, b1};
  assign dy = b0[7] ? '0 : {{8{b0[5]}}, pb2};
  assign dz = {{12{pb3[3]}}, pb3[3:0]};  // zero on 3-byte mice

  assign new_report = take & (cnt == LAST);
  assign err_inc    = rx_valid & run & rx_frame.err;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
      x   <= '0;
      y   <= '0;
      z   <= '0;
      btn <= '0;
    end else begin
      if (!run || err_inc) cnt <= '0;  // drop partial packet
      else if (take) begin
        if (cnt == 2'd0 && !rx_frame.data[3]) cnt <= '0;  // out of step, wait for sync bit
        else if (cnt == LAST) cnt <= '0;
        else cnt <= cnt + 2'd1;
      end
      if (clear) begin
        x   <= '0;
        y   <= '0;
        z   <= '0;
        btn <= '0;
      end else if (new_report) begin
        x   <= x + dx;
        y   <= y - dy;  // device y grows upward
        z   <= z + dz;
        btn <= b0[2:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      case (cnt)
        2'd0:    b0 <= rx_frame.data;
        2'd1:    b1 <= rx_frame.data;
        default: b2 <= rx_frame.data;
      endcase
    end
  end

  assign state = '{x: x, y: y, z: z, btn: btn};

endmodule

// ==== rtl/ps2_host_fsm.sv ====
`timescale 1ns/10ps
module ps2_host_fsm (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                restart,
  input  logic                rx_valid,
  input  ps2_pkg::ps2_frame_t rx_frame,
  input  logic                tx_done,
  input  logic                ack_ok,
  input  logic                wd_expired,
  output logic                hold_start,
  output logic                tx_start,
  output logic [7:0]          tx_byte,
  output logic                run,
  output logic                init_fail
);
  import ps2_pkg::*;

  typedef enum logic [2:0] {IDLE, HOLD, SEND, WAIT_ACK, RUN} state_t;

  state_t     state;
  logic [2:0] idx;  // position in INIT_SEQ

  assign hold_start = (state == HOLD);  // timer and shifter start together
  assign tx_start   = (state == HOLD);
  assign tx_byte    = INIT_SEQ[idx];
  assign run        = (state == RUN);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= IDLE;
      idx       <= '0;
      init_fail <= 1'b0;
    end else begin
      init_fail <= 1'b0;
      if (restart) begin
        state <= IDLE;
      end else begin
        case (state)
          IDLE: begin
            idx   <= '0;
            state <= HOLD;
          end
          HOLD: state <= SEND;
          SEND: begin
            if (wd_expired || (tx_done && !ack_ok)) begin
              init_fail <= 1'b1;  // no ack bit, start over
              state     <= IDLE;
            end else if (tx_done) begin
              state <= WAIT_ACK;
            end
          end
          WAIT_ACK: begin
            if (wd_expired || (rx_valid && (rx_frame.err || rx_frame.data != ACK_BYTE))) begin
              init_fail <= 1'b1;
              state     <= IDLE;
            end else if (rx_valid) begin
              if (idx == 3'(INIT_LEN - 1)) begin
                state <= RUN;  // reporting enabled
              end else begin
                idx   <= idx + 3'd1;
                state <= HOLD;
              end
            end
          end
          RUN:     state <= RUN;
          default: state <= IDLE;
        endcase
      end
    end
  end

endmodule

// ==== rtl/ps2_line_timer.sv ====
`timescale 1ns/10ps
module ps2_line_timer #(
  parameter int hold_cycles     = 5000,
  parameter int watchdog_cycles = 20000
) (
  input  logic clk,
  input  logic arst_n,
  input  logic hold_start,
  input  logic clk_edge,
  input  logic in_frame,
  output logic hold_done,
  output logic wd_expired
);

  localparam int MAX_CYC = (hold_cycles > watchdog_cycles) ? hold_cycles : watchdog_cycles;
  localparam int CW      = $clog2(MAX_CYC + 1);

  logic [CW-1:0] cnt;
  logic          hold_act;  // counting the request hold

  // hold and watchdog never run together, clock is ours during the hold
  assign hold_done  = hold_act & (cnt == CW'(hold_cycles - 1));
  assign wd_expired = ~hold_act & in_frame & (cnt == CW'(watchdog_cycles - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt      <= '0;
      hold_act <= 1'b0;
    end else if (hold_start) begin
      cnt      <= '0;
      hold_act <= 1'b1;
    end else if (hold_act) begin
      if (hold_done) begin
        hold_act <= 1'b0;
        cnt      <= '0;
      end else begin
        cnt <= cnt + CW'(1);
      end
    end else if (in_frame && !clk_edge && !wd_expired) begin
      cnt <= cnt + CW'(1);  // time since last fall
    end else begin
      cnt <= '0;
    end
  end

endmodule

// ==== rtl/ps2_frame_shifter.sv ====
`timescale 1ns/10ps
module ps2_frame_shifter #(
  parameter int filter_len = 4
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                ps2_clk,
  input  logic                ps2_dat,
  input  logic                tx_start,
  input  logic [7:0]          tx_byte,
  input  logic                hold_done,
  input  logic                wd_expired,
  output ps2_pkg::ps2_drive_t drive,
  output logic                clk_edge,
  output logic                in_frame,
  output logic                rx_valid,
  output ps2_pkg::ps2_frame_t rx_frame,
  output logic                tx_done,
  output logic                ack_ok
);

  logic [1:0]            clk_sync;  // two-flop synchronizers
  logic [1:0]            dat_sync;
  logic [filter_len-1:0] filt;      // history of clock samples
  logic                  clk_f;     // debounced clock level
  logic                  fall;
  logic                  holding;   // clock pulled low for request
  logic                  tx_mode;
  logic [3:0]            bit_cnt;   // falls seen in this frame
  logic [10:0]           rx_sh;
  logic [10:0]           rx_word;   // frame including the bit on the wire now
  logic [10:0]           tx_sh;     // {stop, parity, data, start}, lsb on the wire
  logic                  frame_bad;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      clk_sync <= 2'b11;
      dat_sync <= 2'b11;
      filt     <= '1;
      clk_f    <= 1'b1;
    end else begin
      clk_sync <= {clk_sync[0], ps2_clk};
      dat_sync <= {dat_sync[0], ps2_dat};
      filt     <= (filt << 1) | filter_len'(clk_sync[1]);
      if (filt == '0) clk_f <= 1'b0;
      else if (filt == '1) clk_f <= 1'b1;  // glitches leave level alone
    end
  end

  // a fall counts only after filter_len low samples, never our own hold
  assign fall     = clk_f & (filt == '0) & ~holding;
  assign clk_edge = fall;
  assign rx_word  = {dat_sync[1], rx_sh[10:1]};
  // start must be 0, odd parity over data+parity, stop must be 1
  assign frame_bad = rx_word[0] | ~(^rx_word[9:1]) | ~rx_word[10];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      holding  <= 1'b0;
      tx_mode  <= 1'b0;
      bit_cnt  <= '0;
      tx_sh    <= '1;
      rx_valid <= 1'b0;
      tx_done  <= 1'b0;
      ack_ok   <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      tx_done  <= 1'b0;
      if (wd_expired) begin
        rx_valid <= ~tx_mode & (bit_cnt != 0);  // hand a dead rx frame on as an error
        holding  <= 1'b0;
        tx_mode  <= 1'b0;
        bit_cnt  <= '0;
        tx_sh    <= '1;
      end else if (tx_start) begin
        holding <= 1'b1;
        tx_mode <= 1'b1;
        bit_cnt <= '0;
        tx_sh   <= {1'b1, ~^tx_byte, tx_byte, 1'b0};
      end else if (holding) begin
        if (hold_done) holding <= 1'b0;  // start bit goes out as clock is freed
      end else if (fall) begin
        bit_cnt <= bit_cnt + 4'd1;
        if (tx_mode) begin
          tx_sh <= {1'b1, tx_sh[10:1]};
          if (bit_cnt == 4'd10) begin
            tx_done <= 1'b1;
            ack_ok  <= ~dat_sync[1];  // device pulls data low to ack
            tx_mode <= 1'b0;
            bit_cnt <= '0;
          end
        end else if (bit_cnt == 4'd10) begin
          rx_valid <= 1'b1;
          bit_cnt  <= '0;
        end
      end
    end
  end

  // receive payload
  always_ff @(posedge clk) begin
    if (wd_expired) begin
      rx_frame.err <= 1'b1;
    end else if (fall && !tx_mode) begin
      rx_sh <= rx_word;
      if (bit_cnt == 4'd10) begin
        rx_frame.data <= rx_word[8:1];
        rx_frame.err  <= frame_bad;
      end
    end
  end

  assign in_frame     = (bit_cnt != 0) | (tx_mode & ~holding);
  assign drive.clk_oe = holding;
  assign drive.dat_oe = ~holding & ~tx_sh[0];

endmodule

// ==== rtl/ps2_pkg.sv ====
package ps2_pkg;

  // one received byte off the wire
  typedef struct packed {
    logic [7:0] data;
    logic       err;  // start, parity, stop or watchdog fault
  } ps2_frame_t;

  typedef logic signed [15:0] pos_t;

  // accumulated pointer state seen by software
  typedef struct packed {
    pos_t       x;
    pos_t       y;
    pos_t       z;
    logic [2:0] btn;  // {middle, right, left}
  } mouse_state_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // open-drain enables, 1 pulls the line low
  typedef struct packed {
    logic clk_oe;
    logic dat_oe;
  } ps2_drive_t;

  // wheel unlock: rate 200, 100, 80, then enable reporting
  localparam int INIT_LEN = 7;
  localparam logic [0:INIT_LEN-1][7:0] INIT_SEQ = {
    8'hF3, 8'hC8, 8'hF3, 8'h64, 8'hF3, 8'h50, 8'hF4
  };
  localparam logic [7:0] ACK_BYTE = 8'hFA;

  localparam logic [7:0] REG_STATUS = 8'h00;
  localparam logic [7:0] REG_CTRL   = 8'h04;
  localparam logic [7:0] REG_X      = 8'h08;
  localparam logic [7:0] REG_Y      = 8'h0C;
  localparam logic [7:0] REG_Z      = 8'h10;
  localparam logic [7:0] REG_BTN    = 8'h14;
  localparam logic [7:0] REG_ERR    = 8'h18;

  // apb response codes
  localparam logic RESP_OKAY   = 1'b0;
  localparam logic RESP_SLVERR = 1'b1;

endpackage
